//--- include/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// Memory depth in words, log2
`define FETCH_MEM_AW 6

// Longest memory read latency, cycles
`define FETCH_LAT_MAX 4

`endif

//--- logic/fetch_ctrl_pkg.sv
`default_nettype none

package fetch_ctrl_pkg;

    // Memory read sequencing
    typedef enum logic [1:0] {
        SRAM_IDLE = 2'd0,
        SRAM_WAIT = 2'd1,
        SRAM_RESP = 2'd2
    } sram_state_e;

    // Occupancy of the one-entry output buffer
    typedef enum logic {
        OBUF_EMPTY = 1'b0,
        OBUF_FULL  = 1'b1
    } obuf_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_out.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_out (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     rsp_valid,
    input  wire fetch_types_pkg::addr_t   rsp_addr,
    input  wire fetch_types_pkg::inst_t   rsp_inst,
    input  wire fetch_types_pkg::epoch_t  rsp_epoch,
    input  wire fetch_types_pkg::epoch_t  cur_epoch,
    output logic                          rsp_ready,
    input  wire logic                     ready,
    output logic                          valid,
    output fetch_types_pkg::addr_t        pc,
    output fetch_types_pkg::inst_t        inst
);

    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;

    obuf_state_e state;
    addr_t       pc_q;
    inst_t       inst_q;
    // Entry leaves to decode this cycle
    logic        drain;
    // Response retires this cycle
    logic        take;
    // Retiring response is current and gets buffered
    logic        keep;

    // ------------------------------------------------
    // Handshakes
    // ------------------------------------------------

    assign valid     = (state == OBUF_FULL);
    assign drain     = valid && ready;
    // Room now, or room made by the drain
    assign rsp_ready = (state == OBUF_EMPTY) || drain;
    assign take      = rsp_valid && rsp_ready;
    // Old generation gets retired but dropped
    assign keep      = take && (rsp_epoch == cur_epoch);

    // ------------------------------------------------
    // Buffer state and entry
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= OBUF_EMPTY;
        end else if (keep) begin
            state <= OBUF_FULL;
        end else if (drain) begin
            state <= OBUF_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            pc_q   <= rsp_addr;
            inst_q <= rsp_inst;
        end
    end

    assign pc   = pc_q;
    assign inst = inst_q;

    // Entry frozen while decode stalls
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(pc) && $stable(inst))
        else $error("fetch_out: entry changed under back-pressure");

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire fetch_types_pkg::addr_t   dnpc,
    input  wire logic                     dnpc_flag,
    input  wire logic                     pipe_stop,
    input  wire logic                     ready,
    output logic                          valid,
    output fetch_types_pkg::addr_t        pc,
    output fetch_types_pkg::inst_t        inst
);

    import fetch_types_pkg::*;

    // Request path
    logic   req_valid;
    logic   req_ready;
    addr_t  req_addr;
    epoch_t req_epoch;
    // Response path
    logic   rsp_valid;
    logic   rsp_ready;
    addr_t  rsp_addr;
    inst_t  rsp_inst;
    epoch_t rsp_epoch;
    // Live generation for stale-drop
    epoch_t cur_epoch;

    // ------------------------------------------------
    // Issue, memory, output
    // ------------------------------------------------

    pc_gen pc_gen_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dnpc      (dnpc),
        .dnpc_flag (dnpc_flag),
        .pipe_stop (pipe_stop),
        .req_ready (req_ready),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_epoch (req_epoch),
        .cur_epoch (cur_epoch)
    );

    inst_sram inst_sram_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_epoch (req_epoch),
        .req_ready (req_ready),
        .rsp_ready (rsp_ready),
        .rsp_valid (rsp_valid),
        .rsp_addr  (rsp_addr),
        .rsp_inst  (rsp_inst),
        .rsp_epoch (rsp_epoch)
    );

    fetch_out fetch_out_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_valid),
        .rsp_addr  (rsp_addr),
        .rsp_inst  (rsp_inst),
        .rsp_epoch (rsp_epoch),
        .cur_epoch (cur_epoch),
        .rsp_ready (rsp_ready),
        .ready     (ready),
        .valid     (valid),
        .pc        (pc),
        .inst      (inst)
    );

endmodule

`default_nettype wire

//--- logic/fetch_types_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_types_pkg;

    // Byte address of an instruction
    typedef logic [31:0] addr_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Word index into the instruction memory
    typedef logic [`FETCH_MEM_AW-1:0] mem_idx_t;

    // Redirect generation, toggles on every redirect
    typedef logic [0:0] epoch_t;

endpackage

`default_nettype wire

//--- logic/inst_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module inst_sram (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     req_valid,
    input  wire fetch_types_pkg::addr_t   req_addr,
    input  wire fetch_types_pkg::epoch_t  req_epoch,
    output logic                          req_ready,
    input  wire logic                     rsp_ready,
    output logic                          rsp_valid,
    output fetch_types_pkg::addr_t        rsp_addr,
    output fetch_types_pkg::inst_t        rsp_inst,
    output fetch_types_pkg::epoch_t       rsp_epoch
);

    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;

    localparam int DEPTH = 1 << `FETCH_MEM_AW;
    // Enough bits to hold latency minus one
    localparam int LAT_W = $clog2(`FETCH_LAT_MAX);

    inst_t            mem [DEPTH];
    sram_state_e      state;
    logic [3:0]       lfsr;
    logic [LAT_W-1:0] lat_draw;
    logic [LAT_W-1:0] lat_cnt;
    addr_t            addr_off;
    mem_idx_t         rd_idx;
    addr_t            addr_q;
    inst_t            inst_q;
    epoch_t           epoch_q;

    // Read-only image
    initial begin
        $readmemh("program.hex", mem);
    end

    // ------------------------------------------------
    // Address to word index
    // ------------------------------------------------

    // Offset from reset pc, word aligned, wraps at depth
    assign addr_off = req_addr - `FETCH_RESET_PC;
    assign rd_idx   = addr_off[`FETCH_MEM_AW+1:2];

    // Extra wait cycles for this request, 0 means one-cycle latency
    assign lat_draw = lfsr[LAT_W-1:0];

    // ------------------------------------------------
    // Control FSM
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= SRAM_IDLE;
            lat_cnt <= '0;
            lfsr    <= 4'b1001;
        end else begin
            // x^4 + x^3 + 1, free running
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
            case (state)
                SRAM_IDLE: begin
                    if (req_valid) begin
                        lat_cnt <= lat_draw - LAT_W'(1);
                        if (lat_draw == '0) begin
                            state <= SRAM_RESP;
                        end else begin
                            state <= SRAM_WAIT;
                        end
                    end
                end
                SRAM_WAIT: begin
                    // Counts down to the last wait cycle
                    if (lat_cnt == '0) begin
                        state <= SRAM_RESP;
                    end else begin
                        lat_cnt <= lat_cnt - LAT_W'(1);
                    end
                end
                SRAM_RESP: begin
                    // Held until fetch_out takes it
                    if (rsp_ready) begin
                        state <= SRAM_IDLE;
                    end
                end
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    // Capture word, address and tag on accept
    always_ff @(posedge clk) begin
        if (state == SRAM_IDLE && req_valid) begin
            addr_q  <= req_addr;
            inst_q  <= mem[rd_idx];
            epoch_q <= req_epoch;
        end
    end

    assign req_ready = (state == SRAM_IDLE);
    assign rsp_valid = (state == SRAM_RESP);
    assign rsp_addr  = addr_q;
    assign rsp_inst  = inst_q;
    assign rsp_epoch = epoch_q;

    // Response held steady under back-pressure
    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_addr)
                                    && $stable(rsp_inst) && $stable(rsp_epoch))
        else $error("inst_sram: response changed before retirement");

endmodule

`default_nettype wire

//--- logic/pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module pc_gen (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire fetch_types_pkg::addr_t   dnpc,
    input  wire logic                     dnpc_flag,
    input  wire logic                     pipe_stop,
    input  wire logic                     req_ready,
    output logic                          req_valid,
    output fetch_types_pkg::addr_t        req_addr,
    output fetch_types_pkg::epoch_t       req_epoch,
    output fetch_types_pkg::epoch_t       cur_epoch
);

    import fetch_types_pkg::*;

    // Next address to fetch
    addr_t  pc_q;
    // Current redirect generation
    epoch_t epoch_q;

    // ------------------------------------------------
    // Request issue
    // ------------------------------------------------

    // Memory idle and pipeline not stalled
    assign req_valid = req_ready && !pipe_stop;
    assign req_addr  = pc_q;
    // Tag goes out with the request, compared later in fetch_out
    assign req_epoch = epoch_q;
    assign cur_epoch = epoch_q;

    // ------------------------------------------------
    // PC and epoch update
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= `FETCH_RESET_PC;
            epoch_q <= '0;
        end else if (dnpc_flag) begin
            // Redirect beats increment, even under stall
            pc_q    <= dnpc;
            // Anything issued before now turns stale
            epoch_q <= ~epoch_q;
        end else if (req_valid) begin
            pc_q <= pc_q + addr_t'(4);
        end
    end

    // Redirect targets are word aligned
    a_dnpc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        dnpc_flag |-> (dnpc[1:0] == 2'b00))
        else $error("pc_gen: redirect target not word aligned");

endmodule

`default_nettype wire

//--- program.hex
// One 32-bit instruction word per line in hex, word index 0 first (pc 8000_0000)
// Word n holds addi x1, x0, n so every index carries a distinct value
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00a00093
00b00093
00c00093
00d00093
00e00093
00f00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01a00093
01b00093
01c00093
01d00093
01e00093
01f00093
02000093
02100093
02200093
02300093
02400093
02500093
02600093
02700093
02800093
02900093
02a00093
02b00093
02c00093
02d00093
02e00093
02f00093
03000093
03100093
03200093
03300093
03400093
03500093
03600093
03700093
03800093
03900093
03a00093
03b00093
03c00093
03d00093
03e00093
03f00093

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fetch testbench with Verilator and run it from the project root,
# where both the memory and the testbench find program.hex
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module fetch_tb -f sources.f -o fetch_tb_sim \
    && ./obj_dir/fetch_tb_sim \
    || { echo "fetch simulation did not complete cleanly"; exit 1; }

//--- sources.f
+incdir+include
logic/fetch_types_pkg.sv
logic/fetch_ctrl_pkg.sv
logic/pc_gen.sv
logic/inst_sram.sv
logic/fetch_out.sv
logic/fetch_top.sv
verification/fetch_tb.sv

//--- verification/fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    import fetch_types_pkg::*;

    localparam int DEPTH      = 1 << `FETCH_MEM_AW;
    localparam int NUM_ROWS   = 6;
    localparam int TAIL_XFERS = 20;

    // Ready duty per row
    localparam logic READY_ALWAYS = 1'b0;
    localparam logic READY_RANDOM = 1'b1;
    // Condition under which the redirect fires
    localparam logic [1:0] REDIR_PLAIN   = 2'd0;
    localparam logic [1:0] REDIR_STOP    = 2'd1;
    localparam logic [1:0] REDIR_PENDING = 2'd2;
    // pipe_stop source for one cycle
    localparam logic [1:0] STOP_RANDOM = 2'd0;
    localparam logic [1:0] STOP_HIGH   = 2'd1;
    localparam logic [1:0] STOP_LOW    = 2'd2;

    typedef struct packed {
        addr_t      target;
        int         count;
        logic       rnd_ready;
        logic [1:0] cond;
    } row_t;

    // Target, transfers before the redirect, ready duty, redirect condition
    row_t rows [NUM_ROWS] = '{
        '{32'h8000_0040,  8, READY_ALWAYS, REDIR_PLAIN},
        '{32'h8000_00f0, 10, READY_RANDOM, REDIR_PLAIN},
        // Runs across word 63 into word 0
        '{32'h8000_0010, 12, READY_RANDOM, REDIR_STOP},
        '{32'h8000_0200,  6, READY_RANDOM, REDIR_PENDING},
        '{32'h8000_0080,  9, READY_ALWAYS, REDIR_PENDING},
        '{32'h8000_00c8,  7, READY_RANDOM, REDIR_STOP}
    };

    logic  clk = 1'b0;
    logic  rst_n;
    addr_t dnpc;
    logic  dnpc_flag;
    logic  pipe_stop;
    logic  ready;
    logic  valid;
    addr_t pc;
    inst_t inst;

    // Reference model state
    inst_t       model_mem [DEPTH];
    logic [31:0] rng;
    addr_t       exp_pc;
    addr_t       redir_target;
    logic        redir_pending;
    int          old_xfers;
    logic        rnd_ready;
    // Transfer due at the coming rising edge
    logic        xfer;
    // Entry held by decode back-pressure
    logic        hold;
    addr_t       hold_pc;
    inst_t       hold_inst;
    int unsigned cycles;
    int unsigned cycle_limit;

    always #4 clk = ~clk;

    fetch_top fetch_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dnpc      (dnpc),
        .dnpc_flag (dnpc_flag),
        .pipe_stop (pipe_stop),
        .ready     (ready),
        .valid     (valid),
        .pc        (pc),
        .inst      (inst)
    );

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Offset from reset pc in words, wrapped to the depth
    function automatic inst_t word_at(input addr_t a);
        mem_idx_t idx;
        idx = mem_idx_t'((a - `FETCH_RESET_PC) >> 2);
        return model_mem[idx];
    endfunction

    function automatic int unsigned transfer_budget();
        int unsigned total;
        total = TAIL_XFERS;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total = total + rows[r].count;
        end
        return 20 * total + 200;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping the run");
    endtask

    // ------------------------------------------------
    // Reference model and per-cycle driver
    // ------------------------------------------------

    task automatic check_transfer(input addr_t got_pc, input inst_t got_inst);
        assert (got_inst === word_at(got_pc))
            else report_mismatch($sformatf("pc %08h carries inst %08h, memory holds %08h",
                                           got_pc, got_inst, word_at(got_pc)));
        if (redir_pending && got_pc === redir_target) begin
            // First fetch from the new target, model back in step
            redir_pending = 1'b0;
            exp_pc = got_pc + 32'd4;
        end else begin
            assert (got_pc === exp_pc)
                else report_mismatch($sformatf("pc %08h, expected %08h", got_pc, exp_pc));
            if (redir_pending) begin
                // Only the buffered entry may leak past a redirect
                old_xfers = old_xfers + 1;
                assert (old_xfers <= 1)
                    else report_mismatch($sformatf("second pre-redirect pc %08h", got_pc));
            end
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic run_cycle(input logic [1:0] stop_sel, input logic ready_low,
                             input logic redir, input addr_t target);
        @(negedge clk);
        if (hold) begin
            assert (valid === 1'b1 && pc === hold_pc && inst === hold_inst)
                else report_mismatch("entry changed while decode stalled");
        end
        assert (!$isunknown(valid))
            else report_mismatch("valid unknown after reset");
        rng = xorshift(rng);
        case (stop_sel)
            STOP_HIGH: pipe_stop = 1'b1;
            STOP_LOW:  pipe_stop = 1'b0;
            default:   pipe_stop = (rng[9:8] == 2'b00);
        endcase
        if (ready_low) begin
            ready = 1'b0;
        end else if (rnd_ready) begin
            ready = (rng[1:0] != 2'b00);
        end else begin
            ready = 1'b1;
        end
        // dnpc carries noise unless the flag is up
        dnpc      = redir ? target : rng;
        dnpc_flag = redir;
        xfer = valid && ready;
        // Same-edge transfer still belongs to the old stream
        if (xfer) begin
            check_transfer(pc, inst);
        end
        hold      = valid && !ready;
        hold_pc   = pc;
        hold_inst = inst;
        if (redir) begin
            redir_pending = 1'b1;
            redir_target  = target;
            old_xfers     = 0;
        end
    endtask

    task automatic observe_transfers(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            run_cycle(STOP_RANDOM, 1'b0, 1'b0, '0);
            if (xfer) begin
                seen = seen + 1;
            end
        end
    endtask

    task automatic fire_redirect(input addr_t target, input logic [1:0] cond);
        assert (!redir_pending)
            else abort_run("previous redirect target never reached decode");
        case (cond)
            REDIR_STOP: begin
                run_cycle(STOP_HIGH, 1'b0, 1'b0, '0);
                run_cycle(STOP_HIGH, 1'b0, 1'b1, target);
                run_cycle(STOP_HIGH, 1'b0, 1'b0, '0);
            end
            REDIR_PENDING: begin
                // Buffer fills, next response queues behind it
                repeat (2 * `FETCH_LAT_MAX + 3) begin
                    run_cycle(STOP_LOW, 1'b1, 1'b0, '0);
                end
                run_cycle(STOP_LOW, 1'b1, 1'b1, target);
            end
            default: begin
                run_cycle(STOP_RANDOM, 1'b0, 1'b1, target);
            end
        endcase
    endtask

    // ------------------------------------------------
    // Run limit
    // ------------------------------------------------

    always @(negedge clk) begin
        cycles = cycles + 1;
        assert (cycles <= cycle_limit)
            else abort_run($sformatf("Timeout: fetch stopped delivering after %0d cycles",
                                     cycles));
    end

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------

    initial begin
        rst_n         = 1'b0;
        dnpc          = '0;
        dnpc_flag     = 1'b0;
        pipe_stop     = 1'b0;
        ready         = 1'b0;
        rng           = 32'h5aae_c6c8;
        exp_pc        = `FETCH_RESET_PC;
        redir_target  = '0;
        redir_pending = 1'b0;
        old_xfers     = 0;
        rnd_ready     = READY_ALWAYS;
        xfer          = 1'b0;
        hold          = 1'b0;
        hold_pc       = '0;
        hold_inst     = '0;
        cycles        = 0;
        cycle_limit   = transfer_budget();
        $readmemh("program.hex", model_mem);

        repeat (16) begin
            @(negedge clk);
        end
        // Nothing fetched yet
        assert (valid === 1'b0)
            else report_mismatch("valid high during reset");
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            rnd_ready = rows[r].rnd_ready;
            observe_transfers(rows[r].count);
            fire_redirect(rows[r].target, rows[r].cond);
        end
        rnd_ready = READY_RANDOM;
        observe_transfers(TAIL_XFERS);
        assert (!redir_pending) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("last redirect target never reached decode");
        end
    end

endmodule

`default_nettype wire
